//--- src/dbg_config.svh
// Layout constants for the fixed two-line dump; the PC and return-stack entries are 20 bits wide.
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

// ----------------------------------------
// CPU state widths
// ----------------------------------------
`define DBG_PC_NIBBLES     5    // hex digits shown for PC and each RSTK entry.
`define DBG_ST_BITS        16   // ST is printed bit by bit.
`define DBG_HST_BITS       4    // HST is printed bit by bit.
`define DBG_RSTK_PTR_BITS  3    // eight return-stack entries.

// ----------------------------------------
// Text buffer and layout
// ----------------------------------------
`define DBG_DUMP_LEN       118  // two lines of 59 characters, newline included.
`define DBG_BUF_ADDR_BITS  7    // 128 entries hold one whole dump.

// Padding runs that keep the columns of both lines aligned.
`define DBG_PC_PAD         13   // spaces after the PC value.
`define DBG_HST_PAD        6    // spaces after the HST bits.
`define DBG_ST_PAD         3    // spaces after the ST bits.

`endif

//--- src/dbg_pkg.sv
// Shared debugger types; the order of field_e is the on-screen order of the dump text.
`include "dbg_config.svh"

package dbg_pkg;

    typedef logic [3:0]                    nibble_t;    // one hex digit.
    typedef logic [7:0]                    char_t;      // one ASCII character.
    typedef logic [19:0]                   addr20_t;    // PC or return-stack value.
    typedef logic [`DBG_BUF_ADDR_BITS-1:0] buf_addr_t;  // text buffer address.

    // ----------------------------------------
    // Layout fields, first line then second line
    // ----------------------------------------
    typedef enum logic [4:0] {
        FLD_PC_LBL,
        FLD_PC_VAL,
        FLD_PC_PAD,
        FLD_CARRY,
        FLD_MODE,
        FLD_RP,
        FLD_R7_LBL,
        FLD_R7_VAL,
        FLD_NL0,
        FLD_P,
        FLD_HST,
        FLD_HST_PAD,
        FLD_ST_LBL,
        FLD_ST_VAL,
        FLD_ST_PAD,
        FLD_R6_LBL,
        FLD_R6_VAL,
        FLD_NL1,
        FLD_DONE
    } field_e;

    typedef enum logic [1:0] {
        CTL_IDLE,
        CTL_FORMAT,
        CTL_SEND,
        CTL_ACK
    } ctl_state_e;

    // Upper-case hex digit.
    function automatic char_t nibble_to_ascii(input nibble_t n);
        return (n < 4'd10) ? char_t'("0" + n) : char_t'("A" + n - 4'd10);
    endfunction

endpackage

//--- src/dbg_dump_control.sv
// Dump sequencer; a request is only taken in idle and the CPU state is frozen on that cycle.
`include "dbg_config.svh"

module dbg_dump_control (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_dump_req,
    input  dbg_pkg::addr20_t              i_pc,
    input  logic                          i_carry,
    input  logic                          i_dec_mode,
    input  logic [`DBG_RSTK_PTR_BITS-1:0] i_rstk_ptr,
    input  dbg_pkg::nibble_t              i_reg_p,
    input  logic [`DBG_HST_BITS-1:0]      i_reg_hst,
    input  logic [`DBG_ST_BITS-1:0]       i_reg_st,
    input  logic                          i_format_done,
    input  logic                          i_send_done,
    output logic                          o_dump_ack,
    output logic                          o_format_start,
    output logic                          o_send_start,
    output dbg_pkg::addr20_t              o_snap_pc,
    output logic                          o_snap_carry,
    output logic                          o_snap_dec_mode,
    output logic [`DBG_RSTK_PTR_BITS-1:0] o_snap_rstk_ptr,
    output dbg_pkg::nibble_t              o_snap_p,
    output logic [`DBG_HST_BITS-1:0]      o_snap_hst,
    output logic [`DBG_ST_BITS-1:0]       o_snap_st
);
    import dbg_pkg::*;

    ctl_state_e state;
    logic       accept;

    assign accept     = (state == CTL_IDLE) && i_dump_req;
    assign o_dump_ack = (state == CTL_ACK);  // held until the core drops its request.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= CTL_IDLE;
            o_format_start <= 1'b0;
            o_send_start   <= 1'b0;
        end else begin
            o_format_start <= 1'b0;  // both starts are single-cycle pulses.
            o_send_start   <= 1'b0;
            case (state)
                CTL_IDLE: begin
                    if (accept) begin
                        state          <= CTL_FORMAT;
                        o_format_start <= 1'b1;
                    end
                end
                CTL_FORMAT: begin
                    if (i_format_done) begin
                        state        <= CTL_SEND;
                        o_send_start <= 1'b1;
                    end
                end
                CTL_SEND: begin
                    if (i_send_done) begin
                        state <= CTL_ACK;
                    end
                end
                default: begin
                    if (!i_dump_req) begin
                        state <= CTL_IDLE;  // ack falls on the next cycle.
                    end
                end
            endcase
        end
    end

    // Snapshot of the visible CPU state, taken on the accepting cycle.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_snap_pc       <= i_pc;
            o_snap_carry    <= i_carry;
            o_snap_dec_mode <= i_dec_mode;
            o_snap_rstk_ptr <= i_rstk_ptr;
            o_snap_p        <= i_reg_p;
            o_snap_hst      <= i_reg_hst;
            o_snap_st       <= i_reg_st;
        end
    end

endmodule

//--- src/dbg_field_formatter.sv
// Writes one character per cycle into the buffer; i_rstk_val must follow o_rstk_ptr combinationally.
`include "dbg_config.svh"

module dbg_field_formatter (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_start,
    input  dbg_pkg::addr20_t              i_snap_pc,
    input  logic                          i_snap_carry,
    input  logic                          i_snap_dec_mode,
    input  logic [`DBG_RSTK_PTR_BITS-1:0] i_snap_rstk_ptr,
    input  dbg_pkg::nibble_t              i_snap_p,
    input  logic [`DBG_HST_BITS-1:0]      i_snap_hst,
    input  logic [`DBG_ST_BITS-1:0]       i_snap_st,
    input  dbg_pkg::addr20_t              i_rstk_val,
    output logic [`DBG_RSTK_PTR_BITS-1:0] o_rstk_ptr,
    output logic                          o_wr_en,
    output dbg_pkg::buf_addr_t            o_wr_addr,
    output dbg_pkg::char_t                o_wr_char,
    output logic                          o_done
);
    import dbg_pkg::*;

    field_e     field;
    logic [4:0] idx;        // character position inside the current field.
    logic [4:0] field_len;
    buf_addr_t  wr_addr;
    char_t      ch;

    // Character i of an n-character string literal.
    function automatic char_t pick(input logic [71:0] s, input int n, input logic [4:0] i);
        return s[(n - 1 - int'(i)) * 8 +: 8];
    endfunction

    function automatic char_t bit_char(input logic b);
        return nibble_to_ascii({3'b000, b});
    endfunction

    // ----------------------------------------
    // Field lengths
    // ----------------------------------------
    always_comb begin
        case (field)
            FLD_PC_LBL:                         field_len = 5'd4;
            FLD_PC_VAL, FLD_R7_VAL, FLD_R6_VAL: field_len = 5'(`DBG_PC_NIBBLES);
            FLD_PC_PAD:                         field_len = 5'(`DBG_PC_PAD);
            FLD_CARRY:                          field_len = 5'd9;
            FLD_MODE, FLD_P:                    field_len = 5'd7;
            FLD_R7_LBL, FLD_R6_LBL:             field_len = 5'd7;
            FLD_RP:                             field_len = 5'd8;
            FLD_HST:                            field_len = 5'(`DBG_HST_BITS + 5);
            FLD_HST_PAD:                        field_len = 5'(`DBG_HST_PAD);
            FLD_ST_LBL:                         field_len = 5'd5;
            FLD_ST_VAL:                         field_len = 5'(`DBG_ST_BITS);
            FLD_ST_PAD:                         field_len = 5'(`DBG_ST_PAD);
            default:                            field_len = 5'd1;  // newlines.
        endcase
    end

    // ----------------------------------------
    // Character of the current position
    // ----------------------------------------
    always_comb begin
        case (field)
            FLD_PC_LBL:  ch = pick("PC: ", 4, idx);
            FLD_PC_VAL:  ch = nibble_to_ascii(i_snap_pc[(`DBG_PC_NIBBLES - 1 - idx) * 4 +: 4]);
            FLD_CARRY:   ch = (idx == 5'd7) ? bit_char(i_snap_carry) : pick("Carry: x ", 9, idx);
            FLD_MODE:    ch = pick(i_snap_dec_mode ? "h: DEC " : "h: HEX ", 7, idx);
            FLD_RP: begin
                ch = (idx == 5'd4) ? nibble_to_ascii(4'(i_snap_rstk_ptr))
                                   : pick("rp: x   ", 8, idx);
            end
            FLD_R7_LBL:  ch = pick("RSTK7: ", 7, idx);
            FLD_R7_VAL,
            FLD_R6_VAL:  ch = nibble_to_ascii(i_rstk_val[(`DBG_PC_NIBBLES - 1 - idx) * 4 +: 4]);
            FLD_NL0,
            FLD_NL1:     ch = 8'h0a;
            FLD_P:       ch = (idx == 5'd4) ? nibble_to_ascii(i_snap_p) : pick("P:  x  ", 7, idx);
            FLD_HST: begin
                ch = (idx >= 5'd5) ? bit_char(i_snap_hst[`DBG_HST_BITS + 4 - idx])
                                   : pick("HST: ", 5, idx);  // bits MSB first.
            end
            FLD_ST_LBL:  ch = pick("ST:  ", 5, idx);
            FLD_ST_VAL:  ch = bit_char(i_snap_st[`DBG_ST_BITS - 1 - idx]);
            FLD_R6_LBL:  ch = pick("RSTK6: ", 7, idx);
            default:     ch = " ";  // all padding runs.
        endcase
    end

    assign o_wr_en   = (field != FLD_DONE);
    assign o_wr_addr = wr_addr;
    assign o_wr_char = ch;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            field      <= FLD_DONE;
            idx        <= '0;
            wr_addr    <= '0;
            o_rstk_ptr <= `DBG_RSTK_PTR_BITS'(7);
            o_done     <= 1'b0;
        end else begin
            o_done <= (field == FLD_NL1);  // the cycle after the last write.
            if (i_start) begin
                field   <= FLD_PC_LBL;
                idx     <= '0;
                wr_addr <= '0;
            end else if (field != FLD_DONE) begin
                wr_addr <= wr_addr + 1'b1;
                if (idx == field_len - 5'd1) begin
                    idx   <= '0;
                    field <= field_e'(field + 1);
                    // The lookup pointer is ready before its value field starts.
                    if (field == FLD_RP) begin
                        o_rstk_ptr <= `DBG_RSTK_PTR_BITS'(7);
                    end
                    if (field == FLD_ST_PAD) begin
                        o_rstk_ptr <= `DBG_RSTK_PTR_BITS'(6);
                    end
                end else begin
                    idx <= idx + 5'd1;
                end
            end
        end
    end

endmodule

//--- src/dbg_text_buffer.sv
// Character memory with a registered read; contents are undefined until the first dump is formatted.
`include "dbg_config.svh"

module dbg_text_buffer (
    input  logic               i_clk,
    input  logic               i_wr_en,
    input  dbg_pkg::buf_addr_t i_wr_addr,
    input  dbg_pkg::char_t     i_wr_char,
    input  dbg_pkg::buf_addr_t i_rd_addr,
    output dbg_pkg::char_t     o_rd_char
);
    import dbg_pkg::*;

    char_t mem [2**`DBG_BUF_ADDR_BITS];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_char;
        end
        o_rd_char <= mem[i_rd_addr];  // data follows the address by one cycle.
    end

endmodule

//--- src/dbg_char_sender.sv
// Streams DBG_DUMP_LEN characters over a four-phase req/ack; the buffer must not change while sending.
`include "dbg_config.svh"

module dbg_char_sender (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_start,
    input  dbg_pkg::char_t     i_rd_char,
    input  logic               i_char_ack,
    output dbg_pkg::buf_addr_t o_rd_addr,
    output dbg_pkg::char_t     o_char,
    output logic               o_char_req,
    output logic               o_done
);
    import dbg_pkg::*;

    typedef enum logic [2:0] {
        SND_IDLE,
        SND_ADDR,  // address applied, read data not yet valid.
        SND_LOAD,
        SND_REQ,
        SND_DROP
    } snd_state_e;

    snd_state_e state;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= SND_IDLE;
            o_rd_addr  <= '0;
            o_char_req <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                SND_IDLE: begin
                    if (i_start) begin
                        o_rd_addr <= '0;
                        state     <= SND_ADDR;
                    end
                end
                SND_ADDR: state <= SND_LOAD;
                SND_LOAD: begin
                    o_char_req <= 1'b1;
                    state      <= SND_REQ;
                end
                SND_REQ: begin
                    if (i_char_ack) begin
                        o_char_req <= 1'b0;
                        state      <= SND_DROP;
                    end
                end
                default: begin
                    if (!i_char_ack) begin  // sink has released the character.
                        if (o_rd_addr == buf_addr_t'(`DBG_DUMP_LEN - 1)) begin
                            o_done <= 1'b1;
                            state  <= SND_IDLE;
                        end else begin
                            o_rd_addr <= o_rd_addr + 1'b1;
                            state     <= SND_ADDR;
                        end
                    end
                end
            endcase
        end
    end

    // Character register, stable from req rise until ack falls.
    always_ff @(posedge i_clk) begin
        if (state == SND_LOAD) begin
            o_char <= i_rd_char;
        end
    end

endmodule

//--- src/dbg_dump_top.sv
// Register-dump debugger top; one dump runs at a time and reset aborts a dump in progress.
`include "dbg_config.svh"

module dbg_dump_top (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_dump_req,
    input  dbg_pkg::addr20_t              i_pc,
    input  logic                          i_carry,
    input  logic                          i_dec_mode,
    input  logic [`DBG_RSTK_PTR_BITS-1:0] i_rstk_ptr,
    input  dbg_pkg::nibble_t              i_reg_p,
    input  logic [`DBG_HST_BITS-1:0]      i_reg_hst,
    input  logic [`DBG_ST_BITS-1:0]       i_reg_st,
    input  dbg_pkg::addr20_t              i_rstk_val,
    input  logic                          i_char_ack,
    output logic                          o_dump_ack,
    output logic [`DBG_RSTK_PTR_BITS-1:0] o_rstk_ptr,
    output dbg_pkg::char_t                o_char,
    output logic                          o_char_req
);
    import dbg_pkg::*;

    // ----------------------------------------
    // Snapshot and sequencing
    // ----------------------------------------
    addr20_t                       snap_pc;
    logic                          snap_carry;
    logic                          snap_dec_mode;
    logic [`DBG_RSTK_PTR_BITS-1:0] snap_rstk_ptr;
    nibble_t                       snap_p;
    logic [`DBG_HST_BITS-1:0]      snap_hst;
    logic [`DBG_ST_BITS-1:0]       snap_st;
    logic                          format_start;
    logic                          format_done;
    logic                          send_start;
    logic                          send_done;

    // ----------------------------------------
    // Buffer ports
    // ----------------------------------------
    logic      wr_en;
    buf_addr_t wr_addr;
    char_t     wr_char;
    buf_addr_t rd_addr;
    char_t     rd_char;

    dbg_dump_control control_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_dump_req      (i_dump_req),
        .i_pc            (i_pc),
        .i_carry         (i_carry),
        .i_dec_mode      (i_dec_mode),
        .i_rstk_ptr      (i_rstk_ptr),
        .i_reg_p         (i_reg_p),
        .i_reg_hst       (i_reg_hst),
        .i_reg_st        (i_reg_st),
        .i_format_done   (format_done),
        .i_send_done     (send_done),
        .o_dump_ack      (o_dump_ack),
        .o_format_start  (format_start),
        .o_send_start    (send_start),
        .o_snap_pc       (snap_pc),
        .o_snap_carry    (snap_carry),
        .o_snap_dec_mode (snap_dec_mode),
        .o_snap_rstk_ptr (snap_rstk_ptr),
        .o_snap_p        (snap_p),
        .o_snap_hst      (snap_hst),
        .o_snap_st       (snap_st)
    );

    dbg_field_formatter formatter_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_start         (format_start),
        .i_snap_pc       (snap_pc),
        .i_snap_carry    (snap_carry),
        .i_snap_dec_mode (snap_dec_mode),
        .i_snap_rstk_ptr (snap_rstk_ptr),
        .i_snap_p        (snap_p),
        .i_snap_hst      (snap_hst),
        .i_snap_st       (snap_st),
        .i_rstk_val      (i_rstk_val),
        .o_rstk_ptr      (o_rstk_ptr),
        .o_wr_en         (wr_en),
        .o_wr_addr       (wr_addr),
        .o_wr_char       (wr_char),
        .o_done          (format_done)
    );

    dbg_text_buffer buffer_i (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_char (wr_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char)
    );

    dbg_char_sender sender_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (send_start),
        .i_rd_char  (rd_char),
        .i_char_ack (i_char_ack),
        .o_rd_addr  (rd_addr),
        .o_char     (o_char),
        .o_char_req (o_char_req),
        .o_done     (send_done)
    );

endmodule

//--- tests/dbg_dump_tb.sv
// Directed testbench for dbg_dump_top; the return stack must not change while a dump is formatted.
`include "dbg_config.svh"

module dbg_dump_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dbg_pkg::*;

    localparam int WAIT_LIMIT = 400;  // cycles any single wait may take.

    logic                          i_clk;
    logic                          i_reset;
    logic                          i_dump_req;
    addr20_t                       i_pc;
    logic                          i_carry;
    logic                          i_dec_mode;
    logic [`DBG_RSTK_PTR_BITS-1:0] i_rstk_ptr;
    nibble_t                       i_reg_p;
    logic [`DBG_HST_BITS-1:0]      i_reg_hst;
    logic [`DBG_ST_BITS-1:0]       i_reg_st;
    addr20_t                       i_rstk_val;
    logic                          i_char_ack;
    logic                          o_dump_ack;
    logic [`DBG_RSTK_PTR_BITS-1:0] o_rstk_ptr;
    char_t                         o_char;
    logic                          o_char_req;

    addr20_t     rstk_mem [8];                   // return stack of the core.
    char_t       exp_text [`DBG_DUMP_LEN];
    char_t       got_text [`DBG_DUMP_LEN + 1];   // one spare slot holds an overlong dump.
    int          model_pos;
    int          got_count;
    int          checks;
    int          err_count;
    logic        timed_out;
    logic [31:0] rng_state;
    string       hex_digits = "0123456789ABCDEF";

    dbg_dump_top dut_i (.*);

    assign i_rstk_val = rstk_mem[o_rstk_ptr];  // combinational lookup answer.

    always #2 i_clk = ~i_clk;

    // ----------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic tick();
        @(posedge i_clk);
        #1;  // drive and sample away from the edge.
    endtask

    task automatic check_char(input string name, input char_t got, input char_t exp);
        checks++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t: %s got 8'h%02h expected 8'h%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            err_count++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        err_count++;
        timed_out = 1'b1;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    // ----------------------------------------
    // Expected text
    // ----------------------------------------
    task automatic put_text(input string s);
        for (int k = 0; k < s.len(); k++) begin
            exp_text[model_pos] = s[k];
            model_pos++;
        end
    endtask

    task automatic put_hex(input addr20_t v, input int n);
        for (int k = n - 1; k >= 0; k--) begin
            exp_text[model_pos] = hex_digits[v[k*4 +: 4]];  // most significant digit first.
            model_pos++;
        end
    endtask

    task automatic put_bits(input logic [15:0] v, input int n);
        for (int k = n - 1; k >= 0; k--) begin
            exp_text[model_pos] = v[k] ? "1" : "0";
            model_pos++;
        end
    endtask

    task automatic put_spaces(input int n);
        repeat (n) put_text(" ");
    endtask

    task automatic build_model();
        model_pos = 0;
        put_text("PC: ");
        put_hex(i_pc, `DBG_PC_NIBBLES);
        put_spaces(`DBG_PC_PAD);
        put_text("Carry: ");
        put_bits(16'(i_carry), 1);
        put_text(i_dec_mode ? " h: DEC rp: " : " h: HEX rp: ");
        put_hex(20'(i_rstk_ptr), 1);
        put_text("   RSTK7: ");
        put_hex(rstk_mem[7], `DBG_PC_NIBBLES);
        put_text("\nP:  ");
        put_hex(20'(i_reg_p), 1);
        put_text("  HST: ");
        put_bits(16'(i_reg_hst), `DBG_HST_BITS);
        put_spaces(`DBG_HST_PAD);
        put_text("ST:  ");
        put_bits(i_reg_st, `DBG_ST_BITS);
        put_spaces(`DBG_ST_PAD);
        put_text("RSTK6: ");
        put_hex(rstk_mem[6], `DBG_PC_NIBBLES);
        put_text("\n");
    endtask

    // ----------------------------------------
    // Stimulus and sink
    // ----------------------------------------
    task automatic randomize_state(input logic with_stack);
        logic [31:0] r;
        r          = next_random();
        i_pc       = r[19:0];
        i_carry    = r[20];
        i_dec_mode = r[21];
        i_rstk_ptr = r[24:22];
        i_reg_p    = r[28:25];
        r          = next_random();
        i_reg_hst  = r[3:0];
        i_reg_st   = r[31:16];
        if (with_stack) begin
            for (int k = 0; k < 8; k++) begin
                rstk_mem[k] = 20'(next_random());
            end
        end
    endtask

    // Collects characters until the limit is reached or the dump is acknowledged.
    task automatic collect_chars(input int limit, input int max_delay);
        int wait_n;
        int delay;
        got_count = 0;
        while (got_count < limit && !timed_out && !o_dump_ack) begin
            wait_n = 0;
            while (!o_char_req && !o_dump_ack && wait_n < WAIT_LIMIT) begin
                tick();
                wait_n++;
            end
            if (!o_char_req && !o_dump_ack) begin
                note_timeout("o_char_req to rise");
            end else if (o_char_req) begin
                got_text[got_count] = o_char;
                got_count++;
                delay = int'(next_random() % 32'(max_delay + 1));
                repeat (delay) tick();
                i_char_ack = 1'b1;
                wait_n = 0;
                while (o_char_req && wait_n < WAIT_LIMIT) begin
                    tick();
                    wait_n++;
                end
                if (o_char_req) begin
                    note_timeout("o_char_req to fall");
                end
                check_char("o_char held", o_char, got_text[got_count-1]);
                i_char_ack = 1'b0;
            end
        end
    endtask

    // The model is taken from the inputs that the accepting edge samples.
    task automatic start_dump(input logic scramble);
        build_model();
        i_dump_req = 1'b1;
        tick();
        if (scramble) begin
            randomize_state(1'b0);
        end
    endtask

    task automatic finish_dump(input int hold);
        int wait_n;
        wait_n = 0;
        while (!o_dump_ack && !o_char_req && !timed_out && wait_n < WAIT_LIMIT) begin
            tick();
            wait_n++;
        end
        if (o_char_req) begin
            err_count++;
            $display("Sender asked for a character beyond the end of the dump");
        end else if (!o_dump_ack && !timed_out) begin
            note_timeout("o_dump_ack to rise");
        end
        repeat (hold) begin
            tick();
            check_flag("o_dump_ack while requested", o_dump_ack, 1'b1);
        end
        i_dump_req = 1'b0;
        tick();
        check_flag("o_dump_ack after release", o_dump_ack, 1'b0);
        check_count("characters sent", got_count, `DBG_DUMP_LEN);
        for (int k = 0; k < got_count && k < `DBG_DUMP_LEN; k++) begin
            check_char($sformatf("o_char[%0d]", k), got_text[k], exp_text[k]);
        end
    endtask

    task automatic run_dump(input logic scramble, input int max_delay, input int hold);
        start_dump(scramble);
        collect_chars(`DBG_DUMP_LEN + 1, max_delay);
        finish_dump(hold);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%-18s %s", name, (err_count == errs_before) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_fixed_dump();
        int errs;
        errs       = err_count;
        i_pc       = 20'h1A2B3;
        i_carry    = 1'b0;
        i_dec_mode = 1'b0;
        i_rstk_ptr = 3'd3;
        i_reg_p    = 4'hC;
        i_reg_hst  = 4'b1010;
        i_reg_st   = 16'h5A0F;
        for (int k = 0; k < 8; k++) begin
            rstk_mem[k] = 20'(k * 32'h11111);
        end
        rstk_mem[7] = 20'hE4D21;
        rstk_mem[6] = 20'h09F3A;
        run_dump(1'b0, 0, 0);
        report_test("fixed dump", errs);
    endtask

    task automatic test_mode_carry();
        int errs;
        errs = err_count;
        for (int c = 0; c < 4; c++) begin
            i_carry    = c[0];
            i_dec_mode = c[1];
            run_dump(1'b0, 0, 0);
        end
        report_test("mode and carry", errs);
    endtask

    task automatic test_random_state();
        int errs;
        errs = err_count;
        repeat (10) begin
            randomize_state(1'b1);
            run_dump(1'b0, 0, 0);
        end
        report_test("random state", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = err_count;
        repeat (4) begin
            randomize_state(1'b1);
            run_dump(1'b1, 7, 0);  // inputs change right after acceptance.
        end
        report_test("back-pressure", errs);
    endtask

    task automatic test_protocol();
        int errs;
        errs = err_count;
        repeat (20) begin
            tick();
            check_flag("o_char_req without request", o_char_req, 1'b0);
        end
        randomize_state(1'b1);
        run_dump(1'b0, 2, 5);
        report_test("protocol", errs);
    endtask

    task automatic test_reset_mid_dump();
        int errs;
        errs = err_count;
        randomize_state(1'b1);
        start_dump(1'b0);
        collect_chars(40, 1);
        i_reset    = 1'b1;
        i_dump_req = 1'b0;
        repeat (2) tick();
        i_reset = 1'b0;
        tick();
        check_flag("o_char_req after reset", o_char_req, 1'b0);
        check_flag("o_dump_ack after reset", o_dump_ack, 1'b0);
        randomize_state(1'b1);
        run_dump(1'b0, 1, 0);
        report_test("reset mid-dump", errs);
    endtask

    initial begin
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_dump_req = 1'b0;
        i_pc       = '0;
        i_carry    = 1'b0;
        i_dec_mode = 1'b0;
        i_rstk_ptr = '0;
        i_reg_p    = '0;
        i_reg_hst  = '0;
        i_reg_st   = '0;
        i_char_ack = 1'b0;
        rng_state  = 32'h0b76c7ec;
        checks     = 0;
        err_count  = 0;
        timed_out  = 1'b0;
        for (int k = 0; k < 8; k++) begin
            rstk_mem[k] = '0;
        end
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        tick();
        test_fixed_dump();
        test_mode_carry();
        test_random_state();
        test_back_pressure();
        test_protocol();
        test_reset_mid_dump();
        $display("checks %0d, errors %0d", checks, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/dbg_pkg.sv
src/dbg_dump_control.sv
src/dbg_field_formatter.sv
src/dbg_text_buffer.sv
src/dbg_char_sender.sv
src/dbg_dump_top.sv
tests/dbg_dump_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the dump debugger testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module dbg_dump_tb \
    -o dbg_dump_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dbg_dump_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
